// File: design/bubble_pkg.sv
`default_nettype none

package bubble_pkg;

    ////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////

    // blink half-period in MCLK cycles
    localparam int BLINK_HALF    = 16;
    // idle cycles between two sensor frames
    localparam int SAMPLE_GAP    = 64;
    localparam int FRAME_BITS    = 16;
    // each temp_clk period spans two MCLK cycles
    localparam int FRAME_CYCLES  = 2 * FRAME_BITS;
    localparam int PERIOD_CYCLES = FRAME_CYCLES + SAMPLE_GAP;
    // lowest reading bit inside the sensor frame
    localparam int TEMP_LSB      = 3;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef logic [8:0]                          dip_t;
    // 1/16 degree units
    typedef logic signed [12:0]                  temp_t;
    typedef logic [$clog2(PERIOD_CYCLES)-1:0]    seq_cnt_t;
    typedef logic [$clog2(BLINK_HALF)-1:0]       blink_cnt_t;

    // 40 degrees
    localparam temp_t FAN_ON_TEMP = 13'sd640;
    // 5 degrees per delay_sel step
    localparam temp_t COLD_STEP   = 13'sd80;

    typedef struct packed {
        logic       bitwidth4;
        logic       timing_sel;
        logic       flash_type;
        logic       fan_allow;
        logic [1:0] delay_sel;
        logic [2:0] image_num;
    } settings_t;

    typedef enum logic [2:0] {
        MODE_RESET       = 3'd0,
        MODE_SELECT      = 3'd1,
        MODE_EMULATOR    = 3'd2,
        MODE_USB_STANDBY = 3'd3,
        MODE_ERR_BOARD   = 3'd4,
        MODE_ERR_USB     = 3'd5
    } mode_t;

    // all active high
    typedef struct packed {
        logic pwrok;
        logic standby;
        logic delaying;
    } led_t;

endpackage

`default_nettype wire

// File: design/led_blinker.sv
`timescale 1ns/1ps
`default_nettype none

module led_blinker
(
    input  wire   MCLK,
    input  wire   MRST,
    input  wire   blink_en,
    output logic  blink
);

bubble_pkg::blink_cnt_t half_cnt;
logic                   half_done;

assign half_done = half_cnt == bubble_pkg::blink_cnt_t'(bubble_pkg::BLINK_HALF - 1);

////////////////////////////////////////////////////////////
// half-period divider
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST || !blink_en)
    begin
        half_cnt <= '0;
    end
    else if (half_done)
    begin
        half_cnt <= '0;
    end
    else
    begin
        half_cnt <= half_cnt + 1'b1;
    end
end

// phase rests high while stopped
always_ff @(posedge MCLK)
begin
    if (MRST || !blink_en)
        blink <= 1'b1;
    else if (half_done)
        blink <= ~blink;
end

endmodule

`default_nettype wire

// File: design/temp_sense.sv
`timescale 1ns/1ps
`default_nettype none

module temp_sense
(
    input  wire                 MCLK,
    input  wire                 MRST,
    input  wire                 sense_en,

    // latched switch settings
    input  wire [1:0]           delay_sel,
    input  wire                 fan_allow,
    input  wire                 force_start,

    // TC77-style serial interface
    output logic                temp_cs,
    output logic                temp_clk,
    input  wire                 temp_sio,

    output bubble_pkg::temp_t   temp,
    output logic                temp_low,
    output logic                fan_en,
    output logic                delaying
);

bubble_pkg::seq_cnt_t               seq_cnt;
logic                               seq_last;
logic                               in_frame;
logic                               clk_rise;
logic                               frame_done;
logic [bubble_pkg::FRAME_BITS-1:0]  shift_q;
bubble_pkg::temp_t                  frame_temp;
bubble_pkg::temp_t                  cold_limit;

// position inside frame plus gap
assign seq_last   = seq_cnt == bubble_pkg::seq_cnt_t'(bubble_pkg::PERIOD_CYCLES - 1);
assign in_frame   = seq_cnt < bubble_pkg::seq_cnt_t'(bubble_pkg::FRAME_CYCLES);
// odd cycles of the frame raise temp_clk
assign clk_rise   = in_frame && seq_cnt[0];
assign frame_done = seq_cnt == bubble_pkg::seq_cnt_t'(bubble_pkg::FRAME_CYCLES);

////////////////////////////////////////////////////////////
// frame sequencer
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST || !sense_en)
    begin
        seq_cnt  <= '0;
        temp_cs  <= 1'b1;
        temp_clk <= 1'b0;
    end
    else
    begin
        if (seq_last)
            seq_cnt <= '0;
        else
            seq_cnt <= seq_cnt + 1'b1;

        temp_cs  <= !in_frame;
        temp_clk <= clk_rise;
    end
end

// sampled together with the temp_clk rise, msb first
always_ff @(posedge MCLK)
begin
    if (sense_en && clk_rise)
        shift_q <= {shift_q[bubble_pkg::FRAME_BITS-2:0], temp_sio};
end

////////////////////////////////////////////////////////////
// thresholds
////////////////////////////////////////////////////////////

// low three bits of the frame are status, not reading
assign frame_temp = bubble_pkg::temp_t'(shift_q[bubble_pkg::FRAME_BITS-1:bubble_pkg::TEMP_LSB]);

// 0, 5, 10 or 15 degrees
assign cold_limit = bubble_pkg::temp_t'(delay_sel) * bubble_pkg::COLD_STEP;

always_ff @(posedge MCLK)
begin
    if (MRST || !sense_en)
    begin
        temp_low <= 1'b0;
        fan_en   <= 1'b0;
    end
    else if (frame_done)
    begin
        temp_low <= frame_temp < cold_limit;
        fan_en   <= fan_allow && (frame_temp >= bubble_pkg::FAN_ON_TEMP);
    end
end

// last complete reading, updated as temp_cs rises
always_ff @(posedge MCLK)
begin
    if (sense_en && frame_done)
        temp <= frame_temp;
end

// startup is only delayed while nobody forces it
assign delaying = temp_low && !force_start;

endmodule

`default_nettype wire

// File: design/startup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module startup_ctrl
(
    input  wire                    MCLK,
    input  wire                    MRST,

    // power status
    input  wire                    usb_pwr,
    input  wire                    board_fault,

    // switches, active low
    input  wire bubble_pkg::dip_t  dip_sw,
    input  wire                    force_start,

    // from sensor reader and blinker
    input  wire                    temp_low,
    input  wire                    delaying,
    input  wire                    blink,

    output bubble_pkg::mode_t      mode,
    output bubble_pkg::settings_t  settings,
    output logic                   bubble_en,
    output logic                   usb_en,
    output logic                   sense_en,
    output logic                   blink_en,
    output bubble_pkg::led_t       leds
);

bubble_pkg::mode_t  state;
bubble_pkg::mode_t  state_next;
logic [1:0]         pwr_stat;
logic               in_emu;
logic               in_standby;
logic               in_error;

assign pwr_stat   = {usb_pwr, board_fault};
assign in_emu     = state == bubble_pkg::MODE_EMULATOR;
assign in_standby = state == bubble_pkg::MODE_USB_STANDBY;
assign in_error   = (state == bubble_pkg::MODE_ERR_BOARD) ||
                    (state == bubble_pkg::MODE_ERR_USB);

////////////////////////////////////////////////////////////
// mode state machine
////////////////////////////////////////////////////////////

always_comb
begin
    state_next = state;
    case (state)
        bubble_pkg::MODE_RESET:
            state_next = bubble_pkg::MODE_SELECT;

        bubble_pkg::MODE_SELECT:
            case (pwr_stat)
                2'b00:   state_next = bubble_pkg::MODE_EMULATOR;
                2'b01:   state_next = bubble_pkg::MODE_ERR_BOARD;
                2'b10:   state_next = bubble_pkg::MODE_ERR_USB;
                default: state_next = bubble_pkg::MODE_USB_STANDBY;
            endcase

        // only a reset leaves emulation
        bubble_pkg::MODE_EMULATOR:
            state_next = bubble_pkg::MODE_EMULATOR;

        // standby and errors hold only while their combination holds
        bubble_pkg::MODE_USB_STANDBY:
            if (pwr_stat != 2'b11)
                state_next = bubble_pkg::MODE_RESET;

        bubble_pkg::MODE_ERR_BOARD:
            if (pwr_stat != 2'b01)
                state_next = bubble_pkg::MODE_RESET;

        bubble_pkg::MODE_ERR_USB:
            if (pwr_stat != 2'b10)
                state_next = bubble_pkg::MODE_RESET;

        default:
            state_next = bubble_pkg::MODE_RESET;
    endcase
end

always_ff @(posedge MCLK)
begin
    if (MRST)
        state <= bubble_pkg::MODE_RESET;
    else
        state <= state_next;
end

// switches sampled on every pass through reset
always_ff @(posedge MCLK)
begin
    if (MRST || state == bubble_pkg::MODE_RESET)
        settings <= bubble_pkg::settings_t'(~dip_sw);
end

////////////////////////////////////////////////////////////
// registered enables and leds
////////////////////////////////////////////////////////////

always_ff @(posedge MCLK)
begin
    if (MRST)
    begin
        mode      <= bubble_pkg::MODE_RESET;
        bubble_en <= 1'b0;
        usb_en    <= 1'b0;
        sense_en  <= 1'b0;
        blink_en  <= 1'b0;
        leds      <= '0;
    end
    else
    begin
        mode      <= state;
        // cold start held off unless forced
        bubble_en <= in_emu && (!temp_low || force_start);
        usb_en    <= in_standby;
        sense_en  <= in_emu;
        blink_en  <= in_standby || in_error;

        leds.pwrok    <= in_emu || ((in_standby || in_error) && blink);
        leds.standby  <= in_standby && blink;
        leds.delaying <= in_emu && delaying;
    end
end

endmodule

`default_nettype wire

// File: design/bubble_supervisor_top.sv
`timescale 1ns/1ps
`default_nettype none

module bubble_supervisor_top
(
    input  wire                    MCLK,
    input  wire                    MRST,

    // power status
    input  wire                    usb_pwr,
    input  wire                    board_fault,

    // front panel
    input  wire bubble_pkg::dip_t  dip_sw,
    input  wire                    force_start,

    // temperature sensor
    input  wire                    temp_sio,
    output logic                   temp_cs,
    output logic                   temp_clk,

    output bubble_pkg::mode_t      mode,
    output bubble_pkg::settings_t  settings,
    output logic                   bubble_en,
    output logic                   usb_en,
    output bubble_pkg::led_t       leds,
    output logic                   temp_low,
    output logic                   fan_en
);

logic               sense_en;
logic               blink_en;
logic               blink;
logic               delaying;

////////////////////////////////////////////////////////////
// control
////////////////////////////////////////////////////////////

startup_ctrl u_startup_ctrl
(
    .MCLK        (MCLK),
    .MRST        (MRST),
    .usb_pwr     (usb_pwr),
    .board_fault (board_fault),
    .dip_sw      (dip_sw),
    .force_start (force_start),
    .temp_low    (temp_low),
    .delaying    (delaying),
    .blink       (blink),
    .mode        (mode),
    .settings    (settings),
    .bubble_en   (bubble_en),
    .usb_en      (usb_en),
    .sense_en    (sense_en),
    .blink_en    (blink_en),
    .leds        (leds)
);

////////////////////////////////////////////////////////////
// datapath blocks
////////////////////////////////////////////////////////////

temp_sense u_temp_sense
(
    .MCLK        (MCLK),
    .MRST        (MRST),
    .sense_en    (sense_en),
    .delay_sel   (settings.delay_sel),
    .fan_allow   (settings.fan_allow),
    .force_start (force_start),
    .temp_cs     (temp_cs),
    .temp_clk    (temp_clk),
    .temp_sio    (temp_sio),
    .temp        (),
    .temp_low    (temp_low),
    .fan_en      (fan_en),
    .delaying    (delaying)
);

led_blinker u_led_blinker
(
    .MCLK        (MCLK),
    .MRST        (MRST),
    .blink_en    (blink_en),
    .blink       (blink)
);

endmodule

`default_nettype wire

// File: test/bubble_supervisor_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bubble_supervisor_properties
(
    input wire                     MCLK,
    input wire                     MRST,
    input wire bubble_pkg::mode_t  mode,
    input wire                     bubble_en,
    input wire                     temp_cs,
    input wire                     temp_low,
    input wire                     fan_en
);

// core only runs out of emulator mode
a_bubble_in_emulator: assert property (
    @(posedge MCLK) disable iff (MRST)
    bubble_en |-> (mode == bubble_pkg::MODE_EMULATOR)
) else $error("bubble_en high outside emulator mode");

// sensor idle in standby and error states
a_sensor_idle: assert property (
    @(posedge MCLK) disable iff (MRST)
    (mode != bubble_pkg::MODE_EMULATOR) |-> temp_cs
) else $error("temp_cs low outside emulator mode");

// fan threshold sits above every cold threshold
a_fan_not_cold: assert property (
    @(posedge MCLK) disable iff (MRST)
    !(fan_en && temp_low)
) else $error("fan_en and temp_low both high");

endmodule

bind bubble_supervisor_top bubble_supervisor_properties u_properties
(
    .MCLK      (MCLK),
    .MRST      (MRST),
    .mode      (mode),
    .bubble_en (bubble_en),
    .temp_cs   (temp_cs),
    .temp_low  (temp_low),
    .fan_en    (fan_en)
);

`default_nettype wire

// File: test/tb_bubble_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bubble_supervisor;

// one table row with the lfsr filling the unlisted switch bits
typedef struct packed {
    logic               usb_pwr;
    logic               board_fault;
    logic               fan_allow;
    logic [1:0]         delay_sel;
    bubble_pkg::temp_t  temp;
    logic               force_start;
    logic               drop_usb;
    bubble_pkg::mode_t  exp_mode;
    logic               exp_bubble;
    logic               exp_usb;
    logic               exp_low;
    logic               exp_fan;
} row_t;

logic                   MCLK;
logic                   MRST;
logic                   usb_pwr;
logic                   board_fault;
bubble_pkg::dip_t       dip_sw;
logic                   force_start;
logic                   temp_sio = 1'b0;
logic                   temp_cs;
logic                   temp_clk;
bubble_pkg::mode_t      mode;
bubble_pkg::settings_t  settings;
logic                   bubble_en;
logic                   usb_en;
bubble_pkg::led_t       leds;
logic                   temp_low;
logic                   fan_en;

logic [15:0]            sensor_word;
int                     bit_idx = 15;
logic [31:0]            lfsr_state;
int                     errors;
int                     cycle_count = 0;
int                     cycle_limit;
row_t                   rows [0:11];

bubble_supervisor_top dut
(
    .MCLK        (MCLK),
    .MRST        (MRST),
    .usb_pwr     (usb_pwr),
    .board_fault (board_fault),
    .dip_sw      (dip_sw),
    .force_start (force_start),
    .temp_sio    (temp_sio),
    .temp_cs     (temp_cs),
    .temp_clk    (temp_clk),
    .mode        (mode),
    .settings    (settings),
    .bubble_en   (bubble_en),
    .usb_en      (usb_en),
    .leds        (leds),
    .temp_low    (temp_low),
    .fan_en      (fan_en)
);

initial
begin
    MCLK = 1'b0;
    forever #50 MCLK = ~MCLK;
end

////////////////////////////////////////////////////////////
// sensor model and run limit
////////////////////////////////////////////////////////////

// next bit goes out msb first as temp_clk falls
always @(posedge MCLK)
begin
    if (temp_cs)
    begin
        temp_sio <= sensor_word[15];
        bit_idx  <= 14;
    end
    else if (temp_clk && bit_idx >= 0)
    begin
        temp_sio <= sensor_word[bit_idx];
        bit_idx  <= bit_idx - 1;
    end
end

always @(posedge MCLK)
begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
        $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
        $display(">>> FAIL");
        $fatal(1, "simulation timeout");
    end
end

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state >> 1;
    if (state[0])
        lfsr_next = lfsr_next ^ 32'h8020_0003;
endfunction

// one lfsr step per bit
task automatic random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
        bits[i]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want)
    begin
        errors = errors + 1;
        $display("error: time %0t: %s is %0h, expected %0h", $time, what, got, want);
        $display(">>> FAIL");
        $fatal(1, "value mismatch");
    end
endtask

task automatic load_table();
    // cold limit is delay_sel times 80 and the fan threshold 640
    rows[0]  = '{1'b0, 1'b0, 1'b0, 2'd2, 13'sd400, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[1]  = '{1'b0, 1'b0, 1'b1, 2'd3, 13'sd32, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b0, 1'b0, 1'b1, 1'b0};
    rows[2]  = '{1'b0, 1'b0, 1'b1, 2'd3, 13'sd32, 1'b1, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b1, 1'b0};
    rows[3]  = '{1'b0, 1'b0, 1'b0, 2'd1, 13'sd80, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[4]  = '{1'b0, 1'b0, 1'b1, 2'd1, 13'sd640, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b0, 1'b1};
    rows[5]  = '{1'b0, 1'b0, 1'b0, 2'd0, 13'sd720, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b0, 1'b0};
    rows[6]  = '{1'b0, 1'b0, 1'b1, 2'd2, 13'sd639, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b1, 1'b0, 1'b0, 1'b0};
    // below zero is still below a zero threshold
    rows[7]  = '{1'b0, 1'b0, 1'b1, 2'd0, -13'sd160, 1'b0, 1'b0,
                 bubble_pkg::MODE_EMULATOR, 1'b0, 1'b0, 1'b1, 1'b0};
    rows[8]  = '{1'b0, 1'b1, 1'b1, 2'd1, 13'sd400, 1'b0, 1'b0,
                 bubble_pkg::MODE_ERR_BOARD, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[9]  = '{1'b1, 1'b0, 1'b1, 2'd1, 13'sd400, 1'b0, 1'b0,
                 bubble_pkg::MODE_ERR_USB, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[10] = '{1'b1, 1'b1, 1'b0, 2'd2, 13'sd400, 1'b0, 1'b0,
                 bubble_pkg::MODE_USB_STANDBY, 1'b0, 1'b1, 1'b0, 1'b0};
    rows[11] = '{1'b1, 1'b1, 1'b1, 2'd3, 13'sd16, 1'b0, 1'b1,
                 bubble_pkg::MODE_USB_STANDBY, 1'b0, 1'b1, 1'b0, 1'b0};
endtask

// power moves from usb to the board so mode passes through reset to emulator
task automatic leave_standby(input int idx);
    logic left;
    logic reached;
    left    = 1'b0;
    reached = 1'b0;
    @(posedge MCLK);
    usb_pwr     <= 1'b0;
    board_fault <= 1'b0;
    for (int i = 0; i < 10 && !reached; i++)
    begin
        @(negedge MCLK);
        if (mode != bubble_pkg::MODE_USB_STANDBY)
            left = 1'b1;
        if (mode == bubble_pkg::MODE_EMULATOR)
            reached = 1'b1;
    end
    check_value(32'(left), 32'd1, $sformatf("row %0d left standby", idx));
    check_value(32'(mode), 32'(bubble_pkg::MODE_EMULATOR),
                $sformatf("row %0d mode after usb_pwr drop", idx));
    check_value(32'(usb_en), 32'd0, $sformatf("row %0d usb_en after usb_pwr drop", idx));
endtask

////////////////////////////////////////////////////////////
// one table row
////////////////////////////////////////////////////////////

task automatic run_row(input row_t row, input int idx);
    bubble_pkg::settings_t  want;
    logic [31:0]            bits;
    logic                   in_emu;
    logic                   exp_delaying;
    logic                   prev_cs;
    logic                   prev_standby;
    int                     rises;
    int                     cyc;
    int                     early;
    int                     total;

    in_emu = row.exp_mode == bubble_pkg::MODE_EMULATOR;
    random_bits(5, bits);
    want.image_num  = bits[2:0];
    want.bitwidth4  = bits[3];
    want.timing_sel = bits[4];
    want.flash_type = lfsr_state[0];
    lfsr_state      = lfsr_next(lfsr_state);
    want.fan_allow  = row.fan_allow;
    want.delay_sel  = row.delay_sel;

    @(posedge MCLK);
    MRST        <= 1'b1;
    usb_pwr     <= row.usb_pwr;
    board_fault <= row.board_fault;
    dip_sw      <= ~want;
    force_start <= row.force_start;
    sensor_word <= {row.temp, 3'b100};
    // 16 reset cycles
    repeat (16) @(posedge MCLK);
    MRST <= 1'b0;
    repeat (4) @(posedge MCLK);
    @(negedge MCLK);
    check_value(32'(mode), 32'(row.exp_mode), $sformatf("row %0d mode after reset", idx));
    check_value(32'(usb_en), 32'(row.exp_usb), $sformatf("row %0d usb_en", idx));
    check_value(32'(settings), 32'(want), $sformatf("row %0d latched settings", idx));
    prev_cs      = temp_cs;
    prev_standby = leds.standby;

    // switches move after latching
    random_bits(9, bits);
    @(posedge MCLK);
    dip_sw <= dip_sw ^ (bits[8:0] | 9'h001);

    rises = 0;
    cyc   = 0;
    early = 0;
    total = 0;
    while (in_emu ? (rises < 3) : (cyc < 3 * bubble_pkg::PERIOD_CYCLES))
    begin
        @(negedge MCLK);
        cyc++;
        if (!prev_cs && temp_cs)
            rises++;
        if (leds.standby != prev_standby)
        begin
            total++;
            if (cyc <= 4 * bubble_pkg::BLINK_HALF)
                early++;
        end
        prev_cs      = temp_cs;
        prev_standby = leds.standby;
    end
    // bubble_en trails temp_low by a cycle
    repeat (2) @(negedge MCLK);

    exp_delaying = in_emu && row.exp_low && !row.force_start;
    check_value(32'(mode), 32'(row.exp_mode), $sformatf("row %0d mode", idx));
    check_value(32'(bubble_en), 32'(row.exp_bubble), $sformatf("row %0d bubble_en", idx));
    check_value(32'(usb_en), 32'(row.exp_usb), $sformatf("row %0d usb_en", idx));
    check_value(32'(temp_low), 32'(row.exp_low), $sformatf("row %0d temp_low", idx));
    check_value(32'(fan_en), 32'(row.exp_fan), $sformatf("row %0d fan_en", idx));
    check_value(32'(leds.delaying), 32'(exp_delaying), $sformatf("row %0d delaying led", idx));
    check_value(32'(settings), 32'(want), $sformatf("row %0d settings after dip_sw change", idx));
    if (in_emu)
        check_value(32'(leds.pwrok), 32'd1, $sformatf("row %0d pwrok led", idx));
    if (row.exp_mode == bubble_pkg::MODE_USB_STANDBY)
        check_value(32'(early >= 2), 32'd1, $sformatf("row %0d standby led blinking", idx));
    else
        check_value(32'(total), 32'd0, $sformatf("row %0d standby led changes", idx));

    if (row.drop_usb)
        leave_standby(idx);
endtask

////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////

initial
begin
    MRST        = 1'b1;
    usb_pwr     = 1'b0;
    board_fault = 1'b0;
    dip_sw      = '1;
    force_start = 1'b0;
    sensor_word = '0;
    lfsr_state  = 32'h9794_5ebd;
    errors      = 0;
    load_table();
    cycle_limit = $size(rows) * (16 + 3 * bubble_pkg::PERIOD_CYCLES + 50);

    for (int r = 0; r < $size(rows); r++)
        run_row(rows[r], r);

    if (errors == 0)
    begin
        $display(">>> PASS");
        $finish;
    end
    else
    begin
        $display(">>> FAIL");
        $fatal(1, "checks failed");
    end
end

endmodule

`default_nettype wire

// File: flist.f
design/bubble_pkg.sv
design/led_blinker.sv
design/temp_sense.sv
design/startup_ctrl.sv
design/bubble_supervisor_top.sv
test/bubble_supervisor_properties.sv
test/tb_bubble_supervisor.sv

// File: Makefile
TOP := tb_bubble_supervisor

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o vsim
	@out="$$(./obj_dir/vsim)"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
